/* Makefile */
SIM  := obj_dir/Vtb_processorci
SRCS := $(shell cat tb.f)

.PHONY: all run clean

all: run

$(SIM): tb.f $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module tb_processorci -f tb.f -o Vtb_processorci

run: $(SIM)
	$(SIM) | tee sim.log
	grep -q '^\*\*\* PASSED \*\*\*$$' sim.log

clean:
	rm -rf obj_dir sim.log

/* hw/accum_core.sv */
`timescale 1ns/10ps

module accum_core (
    input logic      sys_clk,
    input logic      core_reset_i,
    wb_bus_if.master bus
);
    import pci_pkg::*;

    typedef enum logic [2:0] {
        ST_START,    // Leaving reset, bus idle
        ST_FETCH,
        ST_DECODE,
        ST_MEM,      // Operand transfer
        ST_WB,
        ST_HALT
    } state_e;

    state_e               state;
    logic [OPERAND_W-1:0] pc;         // Word index of next instruction
    data_t                acc;
    data_t                instr;
    data_t                mem_data;   // Operand word read from the bus
    opcode_e              op;
    logic [OPERAND_W-1:0] operand;

    // Word index to byte address on the bus
    function automatic addr_t word_to_byte(input logic [OPERAND_W-1:0] word);
        return {{(ADDR_W-OPERAND_W-2){1'b0}}, word, 2'b00};
    endfunction

    assign op      = opcode_e'(instr[DATA_W-1 -: OPCODE_W]);
    assign operand = instr[OPERAND_W-1:0];

    // Bus master side
    assign bus.cyc   = (state == ST_FETCH) || (state == ST_MEM);
    assign bus.stb   = bus.cyc;
    assign bus.we    = (state == ST_MEM) && (op == OP_ST);
    assign bus.addr  = (state == ST_MEM) ? word_to_byte(operand) : word_to_byte(pc);
    assign bus.wdata = acc;

    always_ff @(posedge sys_clk) begin
        if (core_reset_i) begin
            state <= ST_START;
            pc    <= '0;
            acc   <= '0;
        end else begin
            case (state)
                ST_START: begin
                    state <= ST_FETCH;
                end

                ST_FETCH: begin
                    if (bus.ack) begin
                        state <= ST_DECODE;
                    end
                end

                ST_DECODE: begin
                    case (op)
                        OP_LDI: begin
                            acc   <= {{(DATA_W-OPERAND_W){1'b0}}, operand};
                            pc    <= pc + 1'b1;
                            state <= ST_FETCH;
                        end
                        OP_LD, OP_ST, OP_ADD, OP_SUB: begin
                            state <= ST_MEM;   // Needs a second transfer
                        end
                        OP_JNZ: begin
                            pc    <= (acc != '0) ? operand : pc + 1'b1;
                            state <= ST_FETCH;
                        end
                        OP_JMP: begin
                            pc    <= operand;
                            state <= ST_FETCH;
                        end
                        OP_HALT: begin
                            state <= ST_HALT;
                        end
                        default: begin   // Unused encodings fall through as no-ops
                            pc    <= pc + 1'b1;
                            state <= ST_FETCH;
                        end
                    endcase
                end

                ST_MEM: begin
                    if (bus.ack) begin
                        state <= ST_WB;
                    end
                end

                ST_WB: begin
                    case (op)
                        OP_LD:   acc <= mem_data;
                        OP_ADD:  acc <= acc + mem_data;   // Wraps at 32 bits
                        OP_SUB:  acc <= acc - mem_data;
                        default: acc <= acc;              // Store leaves acc alone
                    endcase
                    pc    <= pc + 1'b1;
                    state <= ST_FETCH;
                end

                default: begin
                    state <= ST_HALT;   // Parked until reset
                end
            endcase
        end
    end

    // Instruction and operand capture
    always_ff @(posedge sys_clk) begin
        if ((state == ST_FETCH) && bus.ack) begin
            instr <= bus.rdata;
        end
        if ((state == ST_MEM) && bus.ack) begin
            mem_data <= bus.rdata;
        end
    end

endmodule

/* hw/ci_controller.sv */
`timescale 1ns/10ps

module ci_controller (
    input  logic                       sys_clk,
    input  logic                       reset_i,
    input  logic                       load_valid_i,
    output logic                       load_ready_o,
    input  logic [pci_pkg::MEM_AW-1:0] load_addr_i,
    input  pci_pkg::data_t             load_data_i,
    input  logic                       start_i,
    output logic                       done_o,
    output pci_pkg::data_t             result_o,
    output logic                       core_reset_o,
    wb_bus_if.slave                    core_bus,
    wb_bus_if.master                   mem_bus
);
    import pci_pkg::*;

    typedef enum logic [1:0] {
        PH_LOAD,
        PH_RUN,
        PH_DONE
    } phase_e;

    phase_e            phase;
    logic              load_busy;    // Write to RAM in flight
    logic              start_pend;   // Start seen while a write was in flight
    logic [MEM_AW-1:0] load_addr_q;
    data_t             load_data_q;
    logic              load_fire;
    logic              go_run;
    logic              core_req;
    logic              core_ram_sel;
    logic              core_tohost;
    logic              local_ack;    // Ack for anything outside the RAM
    logic              tohost_hit;

    assign load_ready_o = (phase == PH_LOAD) && !load_busy && !start_pend;
    assign load_fire    = load_valid_i && load_ready_o;
    assign go_run       = (phase == PH_LOAD) && (start_i || start_pend) && !load_fire
                          && (!load_busy || mem_bus.ack);

    assign core_reset_o = (phase == PH_LOAD);
    assign done_o       = (phase == PH_DONE);

    // Core address decode
    assign core_req     = core_bus.cyc && core_bus.stb && (phase != PH_LOAD);
    assign core_ram_sel = core_bus.addr < ADDR_W'(RAM_BYTES);
    assign core_tohost  = core_bus.we && (core_bus.addr == TOHOST_ADDR);
    assign tohost_hit   = (phase == PH_RUN) && local_ack && core_tohost;

    // Loader owns the RAM during load, the core afterwards
    always_comb begin
        if (phase == PH_LOAD) begin
            mem_bus.cyc   = load_busy;
            mem_bus.stb   = load_busy;
            mem_bus.we    = 1'b1;
            mem_bus.addr  = {{(ADDR_W-MEM_AW-2){1'b0}}, load_addr_q, 2'b00};
            mem_bus.wdata = load_data_q;
        end else begin
            mem_bus.cyc   = core_req && core_ram_sel;
            mem_bus.stb   = core_req && core_ram_sel;
            mem_bus.we    = core_bus.we;
            mem_bus.addr  = core_bus.addr;
            mem_bus.wdata = core_bus.wdata;
        end
    end

    assign core_bus.ack   = core_req && (core_ram_sel ? mem_bus.ack : local_ack);
    assign core_bus.rdata = core_ram_sel ? mem_bus.rdata : '0;   // Unmapped reads give zero

    always_ff @(posedge sys_clk) begin
        if (reset_i) begin
            phase      <= PH_LOAD;
            load_busy  <= 1'b0;
            start_pend <= 1'b0;
            local_ack  <= 1'b0;
        end else begin
            if (load_fire) begin
                load_busy <= 1'b1;
            end else if (mem_bus.ack) begin
                load_busy <= 1'b0;
            end

            local_ack <= core_req && !core_ram_sel && !local_ack;

            case (phase)
                PH_LOAD: begin
                    if (go_run) begin
                        phase      <= PH_RUN;
                        start_pend <= 1'b0;
                    end else if (start_i) begin
                        start_pend <= 1'b1;
                    end
                end
                PH_RUN: begin
                    if (tohost_hit) begin
                        phase <= PH_DONE;
                    end
                end
                default: begin
                    phase <= PH_DONE;   // Held until reset
                end
            endcase
        end
    end

    // Load word and result capture
    always_ff @(posedge sys_clk) begin
        if (load_fire) begin
            load_addr_q <= load_addr_i;
            load_data_q <= load_data_i;
        end
        if (tohost_hit) begin
            result_o <= core_bus.wdata;
        end
    end

endmodule

/* hw/pci_pkg.sv */
package pci_pkg;

    // Bus geometry
    localparam int DATA_W    = 32;
    localparam int ADDR_W    = 32;

    // Program and data RAM
    localparam int MEM_WORDS = 256;
    localparam int MEM_AW    = $clog2(MEM_WORDS);   // Word index width
    localparam int RAM_BYTES = MEM_WORDS * 4;       // First byte address past the RAM

    // Instruction word layout
    localparam int OPCODE_W  = 4;    // Top bits of the word
    localparam int OPERAND_W = 16;   // Low bits of the word

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ADDR_W-1:0] addr_t;

    // Result mailbox, sits right after the RAM
    localparam addr_t TOHOST_ADDR = 32'h0000_0400;

    // Encoding 0 halts, so a blank RAM word stops the core
    typedef enum logic [OPCODE_W-1:0] {
        OP_HALT = 4'h0,
        OP_LDI  = 4'h1,   // acc = zero-extended operand
        OP_LD   = 4'h2,   // acc = mem[operand]
        OP_ST   = 4'h3,   // mem[operand] = acc
        OP_ADD  = 4'h4,   // acc = acc + mem[operand]
        OP_SUB  = 4'h5,   // acc = acc - mem[operand]
        OP_JNZ  = 4'h6,   // pc = operand if acc != 0
        OP_JMP  = 4'h7    // pc = operand
    } opcode_e;

endpackage

/* hw/processorci_top.sv */
`timescale 1ns/10ps

module processorci_top (
    input  logic                       sys_clk,
    input  logic                       reset_i,

    // Program load port
    input  logic                       load_valid_i,
    output logic                       load_ready_o,
    input  logic [pci_pkg::MEM_AW-1:0] load_addr_i,   // Word index
    input  pci_pkg::data_t             load_data_i,

    // Run control and result
    input  logic                       start_i,
    output logic                       done_o,
    output pci_pkg::data_t             result_o
);

    logic core_reset;   // Held by the controller until start

    wb_bus_if core_bus ();   // Core to controller
    wb_bus_if mem_bus ();    // Controller to RAM

    ci_controller u_controller (
        .sys_clk      (sys_clk),
        .reset_i      (reset_i),
        .load_valid_i (load_valid_i),
        .load_ready_o (load_ready_o),
        .load_addr_i  (load_addr_i),
        .load_data_i  (load_data_i),
        .start_i      (start_i),
        .done_o       (done_o),
        .result_o     (result_o),
        .core_reset_o (core_reset),
        .core_bus     (core_bus.slave),
        .mem_bus      (mem_bus.master)
    );

    accum_core u_core (
        .sys_clk      (sys_clk),
        .core_reset_i (core_reset),
        .bus          (core_bus.master)
    );

    wb_ram u_ram (
        .sys_clk      (sys_clk),
        .reset_i      (reset_i),
        .bus          (mem_bus.slave)
    );

endmodule

/* hw/wb_bus_if.sv */
`timescale 1ns/10ps

interface wb_bus_if;
    import pci_pkg::*;

    logic  cyc;     // Transfer in progress
    logic  stb;     // Request valid
    logic  we;      // 1 = write, 0 = read
    addr_t addr;    // Byte address
    data_t wdata;
    data_t rdata;   // Valid in the ack cycle
    logic  ack;     // One cycle, ends the transfer

    // Master holds cyc, stb and the fields steady until ack
    modport master (
        output cyc, stb, we, addr, wdata,
        input  rdata, ack
    );

    modport slave (
        input  cyc, stb, we, addr, wdata,
        output rdata, ack
    );

endinterface

/* hw/wb_ram.sv */
`timescale 1ns/10ps

module wb_ram (
    input logic     sys_clk,
    input logic     reset_i,
    wb_bus_if.slave bus
);
    import pci_pkg::*;

    data_t             mem [MEM_WORDS];
    logic [MEM_AW-1:0] word_idx;
    logic              req;
    logic              ack_q;
    data_t             rdata_q;

    assign word_idx = bus.addr[MEM_AW+1:2];   // Drop byte offset
    assign req      = bus.cyc && bus.stb && !ack_q;   // No second ack while acking

    always_ff @(posedge sys_clk) begin
        if (reset_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req;
        end
    end

    // Storage and read port
    always_ff @(posedge sys_clk) begin
        if (req) begin
            if (bus.we) begin
                mem[word_idx] <= bus.wdata;
            end
            rdata_q <= mem[word_idx];
        end
    end

    assign bus.ack   = ack_q;
    assign bus.rdata = rdata_q;

endmodule

/* tb.f */
hw/pci_pkg.sv
hw/wb_bus_if.sv
hw/accum_core.sv
hw/wb_ram.sv
hw/ci_controller.sv
hw/processorci_top.sv
testbench/tb_clock.sv
testbench/tb_processorci.sv

/* testbench/tb_clock.sv */
`timescale 1ns/10ps

module tb_clock (
    input  logic rst_req_i,   // One cycle high starts a new reset pulse
    output logic clk_o,
    output logic rst_o
);
    localparam int HALF_PERIOD = 2;   // 4 ns clock
    localparam int RST_CYCLES  = 3;

    int rst_cnt = RST_CYCLES;   // Reset also held from time zero

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

    always @(posedge clk_o) begin
        if (rst_req_i) begin
            rst_cnt <= RST_CYCLES;
        end else if (rst_cnt > 0) begin
            rst_cnt <= rst_cnt - 1;
        end
    end

    assign rst_o = (rst_cnt > 0);

endmodule

/* testbench/tb_processorci.sv */
`timescale 1ns/10ps

module tb_processorci;
    import pci_pkg::*;

    localparam int N_ENTRIES        = 6;
    localparam int MAX_WORDS        = 16;
    localparam int CYCLES_PER_ENTRY = 2000;   // Watchdog budget
    localparam logic [OPERAND_W-1:0] TOHOST_WORD = OPERAND_W'(TOHOST_ADDR >> 2);

    logic              clk;
    logic              reset;
    logic              rst_req;
    logic              load_valid;
    logic              load_ready;
    logic [MEM_AW-1:0] load_addr;
    data_t             load_data;
    logic              start;
    logic              done;
    data_t             result;

    // Program table with one row per entry
    data_t       prog_words  [N_ENTRIES][MAX_WORDS];
    int          prog_len    [N_ENTRIES];
    data_t       prog_result [N_ENTRIES];   // Expected tohost value
    logic [15:0] lfsr_state;

    tb_clock clk_gen (
        .rst_req_i (rst_req),
        .clk_o     (clk),
        .rst_o     (reset)
    );

    processorci_top UUT (
        .sys_clk      (clk),
        .reset_i      (reset),
        .load_valid_i (load_valid),
        .load_ready_o (load_ready),
        .load_addr_i  (load_addr),
        .load_data_i  (load_data),
        .start_i      (start),
        .done_o       (done),
        .result_o     (result)
    );

    task automatic check_data(input string name, input data_t expected, input data_t actual);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
            $display("*** FAILED ***");
            $fatal(1, "Data mismatch on %s", name);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s expected %b, got %b", $time, name, expected, actual);
            $display("*** FAILED ***");
            $fatal(1, "Flag mismatch on %s", name);
        end
    endtask

    // 16-bit Fibonacci LFSR with taps 16 14 13 11
    function automatic logic next_random_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic data_t encode(input opcode_e op, input logic [OPERAND_W-1:0] operand);
        return {op, {(DATA_W-OPCODE_W-OPERAND_W){1'b0}}, operand};
    endfunction

    task automatic add_word(input int e, input data_t word);
        prog_words[e][prog_len[e]] = word;
        prog_len[e] = prog_len[e] + 1;
    endtask

    task automatic build_programs();
        for (int e = 0; e < N_ENTRIES; e++) begin
            prog_len[e] = 0;
        end

        // Immediate straight to tohost
        add_word(0, encode(OP_LDI, 16'h1234));
        add_word(0, encode(OP_ST, TOHOST_WORD));
        add_word(0, encode(OP_HALT, 16'h0000));
        prog_result[0] = 32'h0000_1234;

        // Bit 15 set so the upper half must stay zero
        add_word(1, encode(OP_LDI, 16'hBEEF));
        add_word(1, encode(OP_ST, TOHOST_WORD));
        add_word(1, encode(OP_HALT, 16'h0000));
        prog_result[1] = 32'h0000_BEEF;

        // FFFFFFF0 + 25 wraps to 15 and minus 20 gives FFFFFFF5
        add_word(2, encode(OP_LD, 16'd8));
        add_word(2, encode(OP_ADD, 16'd9));
        add_word(2, encode(OP_SUB, 16'd10));
        add_word(2, encode(OP_ST, 16'd11));   // Scratch word
        add_word(2, encode(OP_LDI, 16'h0000));
        add_word(2, encode(OP_LD, 16'd11));
        add_word(2, encode(OP_ST, TOHOST_WORD));
        add_word(2, encode(OP_HALT, 16'h0000));
        add_word(2, 32'hFFFF_FFF0);
        add_word(2, 32'h0000_0025);
        add_word(2, 32'h0000_0020);
        add_word(2, 32'h0000_0000);
        prog_result[2] = 32'hFFFF_FFF5;

        // sum += count while count counts down from 5 to 1
        add_word(3, encode(OP_LD, 16'd11));
        add_word(3, encode(OP_ADD, 16'd10));
        add_word(3, encode(OP_ST, 16'd11));
        add_word(3, encode(OP_LD, 16'd10));
        add_word(3, encode(OP_SUB, 16'd12));
        add_word(3, encode(OP_ST, 16'd10));
        add_word(3, encode(OP_JNZ, 16'd0));
        add_word(3, encode(OP_LD, 16'd11));
        add_word(3, encode(OP_ST, TOHOST_WORD));
        add_word(3, encode(OP_HALT, 16'h0000));
        add_word(3, 32'd5);   // count
        add_word(3, 32'd0);   // sum
        add_word(3, 32'd1);
        prog_result[3] = 32'd15;

        // Six times 40000001 wraps to 80000006
        add_word(4, encode(OP_LD, 16'd11));
        add_word(4, encode(OP_ADD, 16'd13));
        add_word(4, encode(OP_ST, 16'd11));
        add_word(4, encode(OP_LD, 16'd10));
        add_word(4, encode(OP_SUB, 16'd12));
        add_word(4, encode(OP_ST, 16'd10));
        add_word(4, encode(OP_JNZ, 16'd0));
        add_word(4, encode(OP_LD, 16'd11));
        add_word(4, encode(OP_ST, TOHOST_WORD));
        add_word(4, encode(OP_HALT, 16'h0000));
        add_word(4, 32'd6);
        add_word(4, 32'd0);
        add_word(4, 32'd1);
        add_word(4, 32'h4000_0001);
        prog_result[4] = 32'h8000_0006;

        // JMP skips the second LDI
        add_word(5, encode(OP_LDI, 16'h0007));
        add_word(5, encode(OP_JMP, 16'd3));
        add_word(5, encode(OP_LDI, 16'h0099));
        add_word(5, encode(OP_ST, TOHOST_WORD));
        add_word(5, encode(OP_HALT, 16'h0000));
        prog_result[5] = 32'h0000_0007;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_req <= 1'b1;
        @(posedge clk);
        rst_req <= 1'b0;
        @(negedge clk);
        while (reset) begin
            @(negedge clk);
        end
        check_flag("done_o", 1'b0, done);
        check_flag("load_ready_o", 1'b1, load_ready);
    endtask

    task automatic load_program(input int e);
        int   w;
        logic ready_seen;
        w = 0;
        @(posedge clk);
        while (w < prog_len[e]) begin
            if (next_random_bit()) begin
                load_valid <= 1'b1;
                load_addr  <= MEM_AW'(w);
                load_data  <= prog_words[e][w];
                ready_seen = 1'b0;
                while (!ready_seen) begin   // Word held until the handshake
                    @(negedge clk);
                    check_flag("done_o", 1'b0, done);
                    ready_seen = load_ready;
                    @(posedge clk);
                end
                load_valid <= 1'b0;
                @(negedge clk);
                check_flag("load_ready_o", 1'b0, load_ready);   // RAM write in flight
                @(posedge clk);
                w++;
            end else begin
                load_valid <= 1'b0;   // Gap cycle
                @(posedge clk);
            end
        end
    endtask

    task automatic run_program(input int e);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        while (!done) begin
            @(negedge clk);
        end
        check_data("result_o", prog_result[e], result);

        // Second start after done
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        repeat (8) begin
            @(negedge clk);
            check_flag("done_o", 1'b1, done);
            check_data("result_o", prog_result[e], result);
        end
    endtask

    initial begin
        rst_req    = 1'b0;
        load_valid = 1'b0;
        load_addr  = '0;
        load_data  = '0;
        start      = 1'b0;
        lfsr_state = 16'd77;
        build_programs();
        for (int e = 0; e < N_ENTRIES; e++) begin
            apply_reset();
            load_program(e);
            run_program(e);
        end
        $display("*** PASSED ***");
        $finish;
    end

    // Watchdog
    initial begin
        repeat (N_ENTRIES * CYCLES_PER_ENTRY) @(posedge clk);
        $display("Timeout: done_o never arrived within %0d cycles",
                 N_ENTRIES * CYCLES_PER_ENTRY);
        $display("*** FAILED ***");
        $fatal(1, "Watchdog expired");
    end

endmodule
